/* all.f */
+incdir+hw
hw/display_pkg.sv
hw/fb_pkg.sv
hw/display_timing.sv
hw/fb_ram.sv
hw/box_painter.sv
hw/fb_scanout.sv
hw/colour_regs.sv
hw/framebuffer_display.sv
testbench/tb_framebuffer_display.sv

/* testbench/tb_framebuffer_display.sv */
/* testbench for the framebuffer display
   table of register setups, own beam model, pixel and sync checks */

`default_nettype none

`include "fb_macros.svh"

module tb_framebuffer_display;

    import fb_pkg::*;

    localparam int h_total      = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int v_total      = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int frame_cycles = h_total * v_total;
    localparam int busy_limit   = frame_cycles + `FB_PIXELS + 560;
    localparam int n_entries    = 7;
    localparam int max_points   = 12;
    // at most four frames per entry, two spare
    localparam longint watchdog_time = longint'(n_entries * 4 + 2) * frame_cycles * 20;

    logic        clk_pix;
    logic        reset;
    logic        reg_we;
    logic [1:0]  reg_addr;
    reg_word_t   reg_wdata;
    logic        draw_busy;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;

    // stimulus table
    logic        tab_write [n_entries];
    logic        tab_rand  [n_entries];
    logic [11:0] tab_fg    [n_entries];
    logic [11:0] tab_bg    [n_entries];
    logic        tab_en    [n_entries];
    logic        tab_draw  [n_entries];
    logic        tab_twice [n_entries];
    int          tab_list  [n_entries];
    int          probe_x   [2][max_points];
    int          probe_y   [2][max_points];
    int          probe_n   [2];

    logic [31:0] lfsr;
    logic [11:0] cur_fg, cur_bg;
    logic        cur_en;
    int          pixel_errors = 0;
    int          sync_errors = 0;
    int          draw_errors = 0;
    int          cycle_count = 0;
    int          e;

    // beam model, positions of what the outputs show now
    int          bx, by;
    logic        locked, prev_hs, prev_vs, h_fall, v_fall, h_seen, v_seen;
    int          h_cycles, v_cycles;
    int          target_x, target_y;
    logic        armed = 1'b0;
    logic [11:0] hit_colour;
    event        pixel_hit;
    event        frame_end;

    framebuffer_display framebuffer_display_inst (
        .clk_pix,
        .reset,
        .reg_we,
        .reg_addr,
        .reg_wdata,
        .draw_busy,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) cycle_count <= cycle_count + 1;

    always @(negedge clk_pix) begin
        if (reset) begin
            locked   = 1'b0;
            prev_hs  = 1'b1;
            prev_vs  = 1'b1;
            h_seen   = 1'b0;
            v_seen   = 1'b0;
            h_cycles = 0;
            v_cycles = 0;
        end else begin
            h_fall = prev_hs && !vga_hsync;
            v_fall = prev_vs && !vga_vsync;
            if (locked) begin
                bx = (bx == h_total - 1) ? 0 : bx + 1;
                if (bx == 0)
                    by = (by == v_total - 1) ? 0 : by + 1;
            end else if (v_fall) begin
                bx     = 0;  // vsync starts at the left of line 490
                by     = `V_ACTIVE + `V_FP;
                locked = 1'b1;
            end
            h_cycles++;
            v_cycles++;
            if (h_fall) begin
                if (h_seen) begin
                    assert (h_cycles == h_total) else begin
                        sync_errors++;
                        $display("FAILED at time %0t: hsync period %0d cycles, expected %0d",
                                 $time, h_cycles, h_total);
                    end
                end
                if (locked) begin
                    assert (bx == `H_ACTIVE + `H_FP) else begin
                        sync_errors++;
                        $display("FAILED at time %0t: hsync fell at x %0d", $time, bx);
                    end
                end
                h_cycles = 0;
                h_seen   = 1'b1;
            end
            if (v_fall) begin
                if (v_seen)
                    assert (v_cycles == frame_cycles) else begin
                        sync_errors++;
                        $display("FAILED at time %0t: vsync period %0d cycles, expected %0d",
                                 $time, v_cycles, frame_cycles);
                    end
                v_cycles = 0;
                v_seen   = 1'b1;
            end
            if (locked && armed && bx == target_x && by == target_y) begin
                hit_colour = {vga_r, vga_g, vga_b};
                armed      = 1'b0;
                -> pixel_hit;
            end
            if (locked && bx == h_total - 1 && by == v_total - 1)
                -> frame_end;
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
    end

    // expected colour straight from the pixel rule
    function automatic logic [11:0] expected_pixel(input int x, input int y);
        if (x >= `H_ACTIVE || y >= `V_ACTIVE || !cur_en)
            return 12'h000;
        if (x >= `FB_WIDTH || y >= `FB_HEIGHT)
            return 12'h000;
        if (x == 0 || x == `FB_WIDTH - 1 || y == 0 || y == `FB_HEIGHT - 1)
            return cur_fg;
        return cur_bg;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic random_colour(output logic [11:0] c);
        c = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsr_step(lfsr);
            c    = {c[10:0], lfsr[0]};
        end
    endtask

    task automatic pick_colours(output logic [11:0] fg, output logic [11:0] bg);
        do begin
            random_colour(fg);
            random_colour(bg);
        end while (fg == bg || fg == 12'h000 || bg == 12'h000);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [11:0] data);
        @(posedge clk_pix);
        reg_we    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk_pix);
        reg_we    <= 1'b0;
    endtask

    task automatic check_draw(input logic en, input logic twice);
        int waited;
        int rise_cycle;
        waited = 0;
        do begin
            @(negedge clk_pix);
            waited++;
        end while (!draw_busy && waited < 4);
        assert (draw_busy) else begin
            draw_errors++;
            $display("draw_busy did not rise after a draw command at time %0t", $time);
        end
        if (draw_busy) begin
            rise_cycle = cycle_count;
            if (twice)
                write_reg(2'd2, {10'd0, 1'b1, en});  // lands while busy
            while (draw_busy && cycle_count - rise_cycle <= busy_limit)
                @(negedge clk_pix);
            assert (!draw_busy) else begin
                draw_errors++;
                $display("draw_busy stayed high past one frame plus clear and border");
            end
            repeat (4) @(negedge clk_pix);
            assert (!draw_busy) else begin
                draw_errors++;
                $display("a draw command given while busy started another pass");
            end
        end
    endtask

    task automatic sample_points(input int list);
        logic [11:0] exp;
        @(frame_end);
        for (int k = 0; k < probe_n[list]; k++) begin
            target_x = probe_x[list][k];
            target_y = probe_y[list][k];
            armed    = 1'b1;
            @(pixel_hit);
            exp = expected_pixel(target_x, target_y);
            assert (hit_colour === exp) else begin
                pixel_errors++;
                $display("FAILED at time %0t: pixel (%0d,%0d) read %h, expected %h",
                         $time, target_x, target_y, hit_colour, exp);
            end
        end
    endtask

    task automatic run_entry(input int i);
        logic [11:0] fg;
        logic [11:0] bg;
        if (tab_write[i]) begin
            fg = tab_fg[i];
            bg = tab_bg[i];
            if (tab_rand[i])
                pick_colours(fg, bg);
            write_reg(2'd0, fg);
            write_reg(2'd1, bg);
            write_reg(2'd2, {10'd0, tab_draw[i], tab_en[i]});
            cur_fg = fg;
            cur_bg = bg;
            cur_en = tab_en[i];
            if (tab_draw[i])
                check_draw(tab_en[i], tab_twice[i]);
        end
        sample_points(tab_list[i]);
    endtask

    task automatic set_entry(input int i, input logic w, input logic r, input logic [11:0] fg,
                             input logic [11:0] bg, input logic en, input logic d,
                             input logic t, input int l);
        tab_write[i] = w;
        tab_rand[i]  = r;
        tab_fg[i]    = fg;
        tab_bg[i]    = bg;
        tab_en[i]    = en;
        tab_draw[i]  = d;
        tab_twice[i] = t;
        tab_list[i]  = l;
    endtask

    task automatic set_point(input int l, input int k, input int x, input int y);
        probe_x[l][k] = x;
        probe_y[l][k] = y;
    endtask

    task automatic load_table();
        // idx write rand fg bg en draw twice list
        set_entry(0, 0, 0, 12'h000, 12'h000, 0, 0, 0, 0);  // reset state
        set_entry(1, 1, 1, 12'h000, 12'h000, 1, 1, 0, 0);  // first box
        set_entry(2, 1, 1, 12'h000, 12'h000, 1, 0, 0, 0);  // recolour only
        set_entry(3, 1, 0, 12'hf00, 12'h00f, 0, 0, 0, 0);  // display off
        set_entry(4, 1, 0, 12'hf00, 12'h00f, 1, 0, 0, 0);  // back on, no redraw
        set_entry(5, 1, 1, 12'h000, 12'h000, 1, 1, 1, 0);  // draw while busy
        set_entry(6, 1, 0, 12'hfff, 12'h0f0, 1, 0, 0, 1);
        // points in raster order
        probe_n[0] = 12;
        set_point(0, 0, 0, 0);
        set_point(0, 1, 80, 0);
        set_point(0, 2, 160, 0);
        set_point(0, 3, 1, 1);
        set_point(0, 4, 80, 60);
        set_point(0, 5, 159, 60);
        set_point(0, 6, 300, 60);
        set_point(0, 7, 700, 60);
        set_point(0, 8, 0, 119);
        set_point(0, 9, 159, 119);
        set_point(0, 10, 80, 120);
        set_point(0, 11, 50, 490);
        probe_n[1] = 5;  // blanking only
        set_point(1, 0, 650, 0);
        set_point(1, 1, 799, 119);
        set_point(1, 2, 640, 300);
        set_point(1, 3, 10, 480);
        set_point(1, 4, 100, 500);
    endtask

    initial begin
        #(watchdog_time);
        $display("timeout, the run did not finish within %0d frames", n_entries * 4 + 2);
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        reg_we    = 1'b0;
        reg_addr  = 2'd0;
        reg_wdata = '0;
        lfsr      = 32'h5a6300ce;
        cur_fg    = 12'h000;
        cur_bg    = 12'h000;
        cur_en    = 1'b0;
        load_table();
        repeat (3) @(posedge clk_pix);
        reset <= 1'b0;
        for (e = 0; e < n_entries; e++)
            run_entry(e);
        $display("error counts: pixel %0d, sync %0d, draw %0d",
                 pixel_errors, sync_errors, draw_errors);
        if (pixel_errors + sync_errors + draw_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/framebuffer_display.sv */
/* framebuffer display top
   timing, registers, box painter, framebuffer memory and vga scanout */

`default_nettype none

module framebuffer_display (
    input  wire logic              clk_pix,
    input  wire logic              reset,
    input  wire logic              reg_we,
    input  wire logic [1:0]        reg_addr,
    input  wire fb_pkg::reg_word_t reg_wdata,
    output logic                   draw_busy,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic [3:0]             vga_r,
    output logic [3:0]             vga_g,
    output logic [3:0]             vga_b
);

    import display_pkg::*;
    import fb_pkg::*;

    coord_t   sx, sy;
    logic     hsync, vsync, de, frame;
    colour_t  fg_colour, bg_colour;
    logic     display_en, draw_req;
    logic     fb_we, fb_bit_write, fb_bit_read;
    fb_addr_t fb_addr_write, fb_addr_read;

    display_timing display_timing_inst (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame
    );

    colour_regs colour_regs_inst (
        .clk_pix,
        .reset,
        .reg_we,
        .reg_addr,
        .reg_wdata,
        .fg_colour,
        .bg_colour,
        .display_en,
        .draw_req
    );

    box_painter box_painter_inst (
        .clk_pix,
        .reset,
        .draw_req,
        .frame,
        .fb_we,
        .fb_addr_write,
        .fb_bit_write,
        .draw_busy
    );

    fb_ram fb_ram_inst (
        .clk_pix,
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .data_in    (fb_bit_write),
        .addr_read  (fb_addr_read),
        .data_out   (fb_bit_read)
    );

    fb_scanout fb_scanout_inst (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame,
        .fg_colour,
        .bg_colour,
        .display_en,
        .fb_addr_read,
        .fb_bit_read,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

`default_nettype wire

/* hw/colour_regs.sv */
/* colour and control registers
   strobe-written, drives the scanout colours and the draw command */

`default_nettype none

module colour_regs (
    input  wire logic              clk_pix,
    input  wire logic              reset,
    input  wire logic              reg_we,
    input  wire logic [1:0]        reg_addr,
    input  wire fb_pkg::reg_word_t reg_wdata,
    output display_pkg::colour_t   fg_colour,
    output display_pkg::colour_t   bg_colour,
    output logic                   display_en,
    output logic                   draw_req
);

    import fb_pkg::*;

    localparam logic [1:0] addr_fg   = 2'd0;
    localparam logic [1:0] addr_bg   = 2'd1;
    localparam logic [1:0] addr_ctrl = 2'd2;

    reg_ctrl_t ctrl;

    always_comb ctrl = reg_wdata.ctrl;  // control view of the write word

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            fg_colour  <= '0;
            bg_colour  <= '0;
            display_en <= 1'b0;
            draw_req   <= 1'b0;
        end else begin
            draw_req <= 1'b0;  // single cycle pulse
            if (reg_we) begin
                case (reg_addr)
                    addr_fg: fg_colour <= reg_wdata.colour;
                    addr_bg: bg_colour <= reg_wdata.colour;
                    addr_ctrl: begin
                        display_en <= ctrl.display_en;
                        draw_req   <= ctrl.draw;
                    end
                    default: ;  // address 3 unused
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fb_scanout.sv */
/* framebuffer scanout
   reads the framebuffer with the beam and maps each bit to a vga colour */

`default_nettype none

`include "fb_macros.svh"

module fb_scanout (
    input  wire logic                 clk_pix,
    input  wire logic                 reset,
    input  wire display_pkg::coord_t  sx,
    input  wire display_pkg::coord_t  sy,
    input  wire logic                 hsync,
    input  wire logic                 vsync,
    input  wire logic                 de,
    input  wire logic                 frame,
    input  wire display_pkg::colour_t fg_colour,
    input  wire display_pkg::colour_t bg_colour,
    input  wire logic                 display_en,
    output fb_pkg::fb_addr_t          fb_addr_read,
    input  wire logic                 fb_bit_read,
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output logic [3:0]                vga_r,
    output logic [3:0]                vga_g,
    output logic [3:0]                vga_b
);

    import display_pkg::*;
    import fb_pkg::*;

    logic     in_region;
    fb_addr_t addr_cnt;  // address of the next region pixel
    logic     region_p1, de_p1, hsync_p1, vsync_p1;
    colour_t  pix_colour;

    always_comb in_region = de && (sx < `FB_WIDTH) && (sy < `FB_HEIGHT);

    // pixel 0,0 must read address 0 in its own cycle
    always_comb fb_addr_read = frame ? '0 : addr_cnt;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (in_region) begin
            addr_cnt <= (fb_addr_read == `FB_PIXELS - 1) ? '0 : fb_addr_read + 1'b1;
        end else begin
            addr_cnt <= fb_addr_read;
        end
    end

    // one cycle to match the ram read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            region_p1 <= 1'b0;
            de_p1     <= 1'b0;
            hsync_p1  <= 1'b1;
            vsync_p1  <= 1'b1;
        end else begin
            region_p1 <= in_region;
            de_p1     <= de;
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
        end
    end

    always_comb begin
        if (!de_p1 || !display_en || !region_p1) begin
            pix_colour = '0;  // blanking, disabled or outside the picture
        end else begin
            pix_colour = fb_bit_read ? fg_colour : bg_colour;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= pix_colour.r;
            vga_g     <= pix_colour.g;
            vga_b     <= pix_colour.b;
        end
    end

    read_in_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        fb_addr_read <= `FB_PIXELS - 1
    );

endmodule

`default_nettype wire

/* hw/box_painter.sv */
/* box painter
   on request waits for frame start, clears the framebuffer, then draws its border */

`default_nettype none

`include "fb_macros.svh"

module box_painter (
    input  wire logic       clk_pix,
    input  wire logic       reset,
    input  wire logic       draw_req,
    input  wire logic       frame,
    output logic            fb_we,
    output fb_pkg::fb_addr_t fb_addr_write,
    output logic            fb_bit_write,
    output logic            draw_busy
);

    import fb_pkg::*;

    localparam fb_addr_t row_step = fb_addr_t'(`FB_WIDTH);
    localparam fb_addr_t last_row = fb_addr_t'((`FB_HEIGHT - 1) * `FB_WIDTH);

    paint_state_t state;
    logic [`FB_ADDRW-1:0] step;  // pixels written in the current pass
    logic step_last;

    always_comb begin
        case (state)
            CLEAR:       step_last = (step == `FB_PIXELS - 1);
            TOP, BOTTOM: step_last = (step == `FB_WIDTH - 1);
            RIGHT, LEFT: step_last = (step == `FB_HEIGHT - 1);
            default:     step_last = 1'b0;
        endcase
    end

    always_comb draw_busy = (state != IDLE);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= IDLE;
            step  <= '0;
            fb_we <= 1'b0;
        end else begin
            case (state)
                IDLE: if (draw_req) state <= WAIT_FRAME;  // requests while busy fall here only
                WAIT_FRAME: begin
                    if (frame) begin
                        state <= CLEAR;
                        step  <= '0;
                        fb_we <= 1'b1;
                    end
                end
                CLEAR, TOP, RIGHT, LEFT, BOTTOM: begin
                    step <= step_last ? '0 : step + 1'b1;
                    if (step_last) begin
                        case (state)
                            CLEAR:   state <= TOP;
                            TOP:     state <= RIGHT;
                            RIGHT:   state <= LEFT;
                            LEFT:    state <= BOTTOM;
                            default: begin
                                state <= IDLE;
                                fb_we <= 1'b0;
                            end
                        endcase
                    end
                end
                default: begin
                    state <= IDLE;
                    fb_we <= 1'b0;
                end
            endcase
        end
    end

    // line walker for the write address
    always_ff @(posedge clk_pix) begin
        case (state)
            WAIT_FRAME: begin
                fb_addr_write <= '0;
                fb_bit_write  <= 1'b0;  // clear pass writes zeros
            end
            CLEAR: begin
                if (step_last) begin
                    fb_addr_write <= '0;
                    fb_bit_write  <= 1'b1;
                end else begin
                    fb_addr_write <= fb_addr_write + 1'b1;
                end
            end
            TOP:    if (!step_last) fb_addr_write <= fb_addr_write + 1'b1;  // ends on top right
            RIGHT:  fb_addr_write <= step_last ? '0 : fb_addr_write + row_step;
            LEFT:   fb_addr_write <= step_last ? last_row : fb_addr_write + row_step;
            BOTTOM: fb_addr_write <= fb_addr_write + 1'b1;
            default: fb_addr_write <= fb_addr_write;
        endcase
    end

    write_in_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        fb_we |-> (fb_addr_write < `FB_PIXELS)
    );

    no_write_when_idle: assert property (
        @(posedge clk_pix) disable iff (reset)
        (state == IDLE || state == WAIT_FRAME) |-> !fb_we
    );

endmodule

`default_nettype wire

/* hw/fb_ram.sv */
/* framebuffer memory
   simple dual-port, 1 bit wide, registered read for block ram */

`default_nettype none

`include "fb_macros.svh"

module fb_ram (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire fb_pkg::fb_addr_t addr_write,
    input  wire logic             data_in,
    input  wire fb_pkg::fb_addr_t addr_read,
    output logic                  data_out
);

    logic mem [`FB_PIXELS];  // contents set by the painter's clear pass

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // data appears the cycle after the address
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

`default_nettype wire

/* hw/display_timing.sv */
/* 480p display timing
   beam counters with registered syncs, data enable and frame start */

`default_nettype none

`include "fb_macros.svh"

module display_timing (
    input  wire logic              clk_pix,
    input  wire logic              reset,
    output display_pkg::coord_t    sx,
    output display_pkg::coord_t    sy,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de,
    output logic                   frame
);

    import display_pkg::*;

    localparam coord_t h_sync_sta = coord_t'(`H_ACTIVE + `H_FP);
    localparam coord_t h_sync_end = coord_t'(`H_ACTIVE + `H_FP + `H_SYNC - 1);
    localparam coord_t h_last     = coord_t'(`H_ACTIVE + `H_FP + `H_SYNC + `H_BP - 1);
    localparam coord_t v_sync_sta = coord_t'(`V_ACTIVE + `V_FP);
    localparam coord_t v_sync_end = coord_t'(`V_ACTIVE + `V_FP + `V_SYNC - 1);
    localparam coord_t v_last     = coord_t'(`V_ACTIVE + `V_FP + `V_SYNC + `V_BP - 1);

    coord_t sx_next;
    coord_t sy_next;

    // position one cycle ahead, so the flags below land with the counters
    always_comb begin
        if (sx == h_last) begin
            sx_next = '0;
            sy_next = (sy == v_last) ? '0 : sy + 1'b1;
        end else begin
            sx_next = sx + 1'b1;
            sy_next = sy;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx    <= h_last;  // first cycle after reset is 0,0
            sy    <= v_last;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= !(sx_next >= h_sync_sta && sx_next <= h_sync_end);  // active low
            vsync <= !(sy_next >= v_sync_sta && sy_next <= v_sync_end);
            de    <= (sx_next < `H_ACTIVE) && (sy_next < `V_ACTIVE);
            frame <= (sx_next == '0) && (sy_next == '0);
        end
    end

    // frame start only where both counters wrapped from their last value
    frame_at_origin: assert property (
        @(posedge clk_pix) disable iff (reset)
        frame |-> (sx == '0 && sy == '0 &&
                   $past(sx) == h_last && $past(sy) == v_last)
    );

endmodule

`default_nettype wire

/* hw/fb_pkg.sv */
/* framebuffer-side types
   addresses, painter states and the register write word */

`default_nettype none

`include "fb_macros.svh"

package fb_pkg;

    typedef logic [`FB_ADDRW-1:0] fb_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_FRAME,  // hold off until the beam restarts
        CLEAR,
        TOP,
        RIGHT,
        LEFT,
        BOTTOM
    } paint_state_t;

    // control word at register address 2
    typedef struct packed {
        logic [9:0] reserved;
        logic       draw;        // bit 1
        logic       display_en;  // bit 0
    } reg_ctrl_t;

    // one write word, seen as a colour or as control bits
    typedef union packed {
        display_pkg::colour_t colour;
        reg_ctrl_t            ctrl;
    } reg_word_t;

endpackage

`default_nettype wire

/* hw/display_pkg.sv */
/* screen-side types
   beam coordinates and the 12-bit rgb colour */

`default_nettype none

`include "fb_macros.svh"

package display_pkg;

    // unsigned screen coordinate, covers blanking too
    typedef logic [`CORDW-1:0] coord_t;

    // 4 bits per channel, matches the vga dac
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colour_t;

endpackage

`default_nettype wire

/* hw/fb_macros.svh */
/* framebuffer and 480p display sizes
   shared by timing, painter, memory and scanout */

`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// framebuffer geometry, 1 bit per pixel
`define FB_WIDTH    160
`define FB_HEIGHT   120
`define FB_PIXELS   (`FB_WIDTH * `FB_HEIGHT)
`define FB_ADDRW    15

// 640x480 at 60 Hz, 800x525 total
`define H_ACTIVE    640
`define H_FP        16
`define H_SYNC      96
`define H_BP        48
`define V_ACTIVE    480
`define V_FP        10
`define V_SYNC      2
`define V_BP        33

`define CORDW       10  // enough for 0..799

`endif
